// File: Bender.yml
package:
  name: spi_flash_master

sources:
  - logic/spiFlashPkg.sv
  - logic/spiRegs.sv
  - logic/spiByteEngine.sv
  - logic/spiFlashTop.sv
  - target: test
    files:
      - tb/flashModel.sv
      - tb/spiFlashChecker.sv
      - tb/spiByteEngine_props.sv
      - tb/spiFlashTb.sv

// File: logic/spiByteEngine.sv
`timescale 1ns/1ps

module spiByteEngine
	import spiFlashPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  spiReqT spiReq,
	output spiRspT spiRsp,
	output logic   sck,
	output logic   csN,
	output logic   sdo,
	input  logic   sdi
);

	// sequencing
	logic                busyQ;
	logic [7:0]          divQ;       // half period minus one, latched per byte
	logic [7:0]          phaseCnt;   // clk within the current half period
	logic [halfCntW-1:0] halfCnt;    // odd values are sck high

	// chip select and data path
	logic             csNQ;
	logic [byteW-1:0] shiftQ;        // tx out at msb, rx in at lsb
	logic             sdiQ;

	// decode
	logic       enable;
	logic       phaseEnd;
	logic       highEnd;
	logic       lastHalf;
	logic       startOk;
	logic       startByte;
	logic       startRel;
	logic [7:0] divNext;

	assign enable = spiReq.ctrl.enable;

	assign phaseEnd = busyQ & (phaseCnt == divQ);
	assign highEnd  = phaseEnd & halfCnt[0];                // sck falls here
	assign lastHalf = (halfCnt == halfCntW'(halfPerByte - 1));

	// a start during a byte is ignored, the register block never sends one
	assign startOk   = spiReq.start & enable & ~busyQ;
	assign startByte = startOk & ~spiReq.cmd.releaseCs;
	assign startRel  = startOk & spiReq.cmd.releaseCs;

	// zero would leave a single clk high phase, too short for the sdi register
	assign divNext = (spiReq.ctrl.clkDiv == 8'd0) ? 8'd1 : spiReq.ctrl.clkDiv;

	// input register on miso
	always_ff @(posedge clk) begin
		sdiQ <= sdi;
	end

	// half period and bit counting
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			busyQ    <= 1'b0;
			divQ     <= clkDivReset;
			phaseCnt <= '0;
			halfCnt  <= '0;
		end else if (!enable) begin
			busyQ    <= 1'b0;          // abort anything in flight
			phaseCnt <= '0;
			halfCnt  <= '0;
		end else if (startByte) begin
			busyQ    <= 1'b1;
			divQ     <= divNext;
			phaseCnt <= '0;
			halfCnt  <= '0;            // begin with a low phase
		end else if (phaseEnd) begin
			phaseCnt <= '0;
			halfCnt  <= halfCnt + 1'b1;    // wraps to zero after the last half
			if (lastHalf) begin
				busyQ <= 1'b0;
			end
		end else if (busyQ) begin
			phaseCnt <= phaseCnt + 8'd1;
		end
	end

	// chip select stays low between bytes until a release command
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			csNQ <= 1'b1;
		end else if (!enable) begin
			csNQ <= 1'b1;
		end else if (startByte) begin
			csNQ <= 1'b0;
		end else if (startRel) begin
			csNQ <= 1'b1;              // no busy for a release
		end
	end

	// circular shift register
	// sdi is taken at the end of the high phase and the same edge moves sdo
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			shiftQ <= '0;
		end else if (startByte) begin
			shiftQ <= spiReq.cmd.txByte;   // msb on sdo in the first low phase
		end else if (highEnd) begin
			shiftQ <= {shiftQ[byteW-2:0], sdiQ};
		end
	end

	// pins, enable gates them without waiting for a clk edge
	assign sck = busyQ & halfCnt[0] & enable;
	assign csN = csNQ | ~enable;
	assign sdo = shiftQ[byteW-1];

	// after the last shift the register holds the whole received byte
	assign spiRsp.busy   = busyQ;
	assign spiRsp.rxByte = shiftQ;

endmodule

// File: logic/spiFlashPkg.sv
package spiFlashPkg;

	// bus geometry
	localparam int wbAddrW = 2;             // word address
	localparam int wbDataW = 32;

	// register map in words
	localparam logic [wbAddrW-1:0] regData = 2'd0;
	localparam logic [wbAddrW-1:0] regCtrl = 2'd1;

	localparam int byteW       = 8;
	localparam int halfPerByte = 2 * byteW;             // sck half periods per byte
	localparam int halfCntW    = $clog2(halfPerByte);

	localparam logic [7:0] clkDivReset = 8'd3;         // 4 clk per sck half period

	// wishbone classic request from the bus master
	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic               we;
		logic [wbAddrW-1:0] adr;
		logic [wbDataW-1:0] dat;
	} wbReqT;

	typedef struct packed {
		logic               ack;
		logic [wbDataW-1:0] dat;
	} wbRspT;

	// data word as written by the host
	typedef struct packed {
		logic [wbDataW-byteW-2:0] pad;
		logic                     releaseCs;   // raise csN and send nothing
		logic [byteW-1:0]         txByte;
	} spiCmdT;

	// data word as read back
	typedef struct packed {
		logic                     busy;
		logic [wbDataW-byteW-2:0] pad;
		logic [byteW-1:0]         rxByte;
	} spiStatT;

	// one register word with two meanings
	typedef union packed {
		spiCmdT  cmd;
		spiStatT stat;
	} spiDataU;

	typedef struct packed {
		logic [wbDataW-10:0] pad;
		logic                enable;       // low keeps the flash deselected
		logic [7:0]          clkDiv;       // half period is clkDiv+1 clk
	} spiCtrlT;

	typedef struct packed {
		logic    start;                    // one clk wide
		spiCmdT  cmd;
		spiCtrlT ctrl;
	} spiReqT;

	typedef struct packed {
		logic             busy;
		logic [byteW-1:0] rxByte;
	} spiRspT;

endpackage

// File: logic/spiFlashTop.sv
`timescale 1ns/1ps

module spiFlashTop
	import spiFlashPkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  wbReqT wbReq,
	output wbRspT wbRsp,
	output logic  sck,
	output logic  csN,
	output logic  sdo,
	input  logic  sdi
);

	spiReqT spiReq;   // start pulse, command and live control
	spiRspT spiRsp;   // busy and received byte

	// wishbone slave with the control and data registers
	spiRegs u_regs (
		.clk    (clk),
		.rstN   (rstN),
		.wbReq  (wbReq),
		.wbRsp  (wbRsp),
		.spiReq (spiReq),
		.spiRsp (spiRsp)
	);

	// mode 0 byte engine driving the flash pins
	spiByteEngine u_engine (
		.clk    (clk),
		.rstN   (rstN),
		.spiReq (spiReq),
		.spiRsp (spiRsp),
		.sck    (sck),
		.csN    (csN),
		.sdo    (sdo),
		.sdi    (sdi)
	);

endmodule

// File: logic/spiRegs.sv
`timescale 1ns/1ps

module spiRegs
	import spiFlashPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  wbReqT  wbReq,
	output wbRspT  wbRsp,
	output spiReqT spiReq,
	input  spiRspT spiRsp
);

	// bus side state
	logic               ackQ;
	logic [wbDataW-1:0] datQ;       // read data returned with ack

	// engine side state
	logic    startQ;
	spiCmdT  cmdQ;
	spiCtrlT ctrlQ;

	// decode
	logic               reqValid;
	logic               isData;
	logic               isCtrl;
	logic               engineBusy;
	logic               dataWrWait;
	logic               accept;
	logic               dataWr;
	logic               ctrlWr;
	spiDataU            wrWord;
	spiDataU            statWord;
	spiCtrlT            ctrlWord;
	logic [wbDataW-1:0] rdDat;

	// a request counts once, the ack cycle itself is not a new request
	assign reqValid = wbReq.cyc & wbReq.stb & ~ackQ;

	assign isData = (wbReq.adr == regData);
	assign isCtrl = (wbReq.adr == regCtrl);

	// start already issued but busy not yet back from the engine
	assign engineBusy = spiRsp.busy | startQ;

	// hold off a data write until the byte in flight is done
	assign dataWrWait = wbReq.we & isData & engineBusy;
	assign accept     = reqValid & ~dataWrWait;

	assign dataWr = accept & wbReq.we & isData;
	assign ctrlWr = accept & wbReq.we & isCtrl;

	assign wrWord   = wbReq.dat;     // command view on write
	assign ctrlWord = wbReq.dat;

	// status view of the data word
	always_comb begin
		statWord             = '0;
		statWord.stat.busy   = engineBusy;
		statWord.stat.rxByte = spiRsp.rxByte;
	end

	// read mux, unmapped words read as zero
	always_comb begin
		rdDat = '0;
		if (isData) begin
			rdDat = statWord;
		end else if (isCtrl) begin
			rdDat = ctrlQ;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			ackQ         <= 1'b0;
			startQ       <= 1'b0;
			ctrlQ.pad    <= '0;
			ctrlQ.enable <= 1'b0;
			ctrlQ.clkDiv <= clkDivReset;
		end else begin
			ackQ   <= accept;                     // one cycle, then reqValid drops
			startQ <= dataWr & ctrlQ.enable;      // disabled writes are dropped
			if (ctrlWr) begin
				ctrlQ.enable <= ctrlWord.enable;
				ctrlQ.clkDiv <= ctrlWord.clkDiv;  // used from the next start
			end
		end
	end

	// payload follows the strobes
	always_ff @(posedge clk) begin
		if (accept) begin
			datQ <= rdDat;
		end
		if (dataWr) begin
			cmdQ <= wrWord.cmd;
		end
	end

	assign wbRsp.ack = ackQ;
	assign wbRsp.dat = datQ;

	assign spiReq.start = startQ;
	assign spiReq.cmd   = cmdQ;
	assign spiReq.ctrl  = ctrlQ;      // live so enable acts at once

endmodule

// File: project.f
logic/spiFlashPkg.sv
logic/spiRegs.sv
logic/spiByteEngine.sv
logic/spiFlashTop.sv
tb/flashModel.sv
tb/spiFlashChecker.sv
tb/spiByteEngine_props.sv
tb/spiFlashTb.sv

// File: tb/flashModel.sv
`timescale 1ns/1ps

module flashModel (
	input  logic sck,
	input  logic csN,
	input  logic sdo,
	output logic sdi
);

	logic [7:0]  rxLog [0:255];  // every byte seen on sdo, in order
	int          rxCount = 0;
	logic [7:0]  rxSh;
	logic [7:0]  txSh = 8'h00;   // msb goes out next
	logic [7:0]  opcode;
	logic [23:0] addr;
	int          bitCnt;
	int          byteIdx;        // byte position since csN fell

	initial sdi = 1'b0;

	// answer for the byte that is about to start
	function automatic logic [7:0] replyByte(input int idx);
		logic [7:0] r;
		r = 8'h00;
		if (opcode == 8'h9f && idx >= 1 && idx <= 3) begin
			r = (idx == 1) ? 8'hef : (idx == 2) ? 8'h40 : 8'h15;  // jedec id
		end else if (opcode == 8'h03 && idx >= 4) begin
			r = (addr[7:0] + 8'(idx - 4)) ^ 8'ha5;   // address walks up by one
		end
		return r;
	endfunction

	always @(negedge csN) begin
		bitCnt  = 0;
		byteIdx = 0;
		opcode  = 8'h00;
		txSh    = 8'h00;
		sdi     = 1'b0;      // nothing to say during the opcode
	end

	// mode 0, master data valid on the rising edge
	always @(posedge sck) begin
		if (!csN) begin
			rxSh = {rxSh[6:0], sdo};
			bitCnt++;
			if (bitCnt == 8) begin
				bitCnt = 0;
				if (rxCount < 256) rxLog[rxCount] = rxSh;
				rxCount++;
				if (byteIdx == 0) opcode = rxSh;
				else if (opcode == 8'h03 && byteIdx <= 3) addr = {addr[15:0], rxSh};
				byteIdx++;
				txSh = replyByte(byteIdx);
			end
		end
	end

	always @(negedge sck) begin
		if (!csN) begin
			sdi  = txSh[7];
			txSh = {txSh[6:0], 1'b0};
		end
	end

endmodule

// File: tb/spiByteEngine_props.sv
`timescale 1ns/1ps

module spiByteEngine_props
	import spiFlashPkg::*;
(
	input logic   clk,
	input logic   rstN,
	input spiReqT spiReq,
	input spiRspT spiRsp,
	input logic   sck,
	input logic   csN,
	input logic   sdo
);

	// no clock toward a deselected flash
	sckIdle: assert property (@(posedge clk) disable iff (!rstN) csN |-> !sck)
		else $error("sck high while csN is high");

	// mode 0, the flash samples during the high phase
	sdoHold: assert property (@(posedge clk) disable iff (!rstN)
		(sck && $past(sck)) |-> $stable(sdo))
		else $error("sdo moved while sck was high");

	// disable clears the select register and the byte in flight, not only the pin gate
	enableGate: assert property (@(posedge clk) disable iff (!rstN)
		!spiReq.ctrl.enable |=> (csN && !spiRsp.busy))
		else $error("csN low or busy after the engine was disabled");

	busyCause: assert property (@(posedge clk) disable iff (!rstN)
		$rose(spiRsp.busy) |-> $past(spiReq.start))
		else $error("busy rose without a start pulse");

endmodule

bind spiByteEngine spiByteEngine_props u_props (
	.clk    (clk),
	.rstN   (rstN),
	.spiReq (spiReq),
	.spiRsp (spiRsp),
	.sck    (sck),
	.csN    (csN),
	.sdo    (sdo)
);

// File: tb/spiFlashChecker.sv
`timescale 1ns/1ps

module spiFlashChecker
	import spiFlashPkg::*;
(
	input logic  clk,
	input logic  rstN,
	input wbReqT wbReq,
	input wbRspT wbRsp
);

	logic [7:0] expQ [$];     // bytes still owed by regData reads
	logic [7:0] expByte;
	wbReqT      lastReq;      // request that the current ack answers
	spiStatT    stat;
	int         errCount = 0;
	int         checkCount = 0;
	int         testCount = 0;
	int         failedTests = 0;
	int         testErrStart;
	int         testNum;
	string      testName;

	task automatic pushExpected(input logic [7:0] b);
		expQ.push_back(b);
	endtask

	task automatic checkValue(
		input string       sig,
		input logic [31:0] got,
		input logic [31:0] exp
	);
		checkCount++;
		if (got !== exp) begin
			errCount++;
			$display("[ERROR] %0d ns %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
		end
	endtask

	task automatic failNote(input string msg);
		errCount++;
		$display("%0d ns: %s", $time, msg);
	endtask

	task automatic beginTest(input int num, input string name);
		testNum      = num;
		testName     = name;
		testErrStart = errCount;
	endtask

	task automatic endTest();
		if (expQ.size() != 0) begin
			failNote($sformatf("%0d expected bytes were never read back", expQ.size()));
			expQ.delete();
		end
		testCount++;
		if (errCount == testErrStart) begin
			$display("test %0d %s: ok", testNum, testName);
		end else begin
			failedTests++;
			$display("test %0d %s: %0d errors", testNum, testName, errCount - testErrStart);
		end
	endtask

	task automatic report();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errCount);
	endtask

	// an idle status read carries the finished byte
	always @(posedge clk) begin
		if (rstN && wbRsp.ack && lastReq.cyc && !lastReq.we && lastReq.adr == regData) begin
			stat = wbRsp.dat;
			if (!stat.busy && expQ.size() > 0) begin
				expByte = expQ.pop_front();
				checkValue("rxByte", stat.rxByte, expByte);
			end
		end
		lastReq = wbReq;   // held by the master until ack
	end

endmodule

// File: tb/spiFlashTb.sv
`timescale 1ns/1ps

module spiFlashTb
	import spiFlashPkg::*;
();

	typedef enum logic [2:0] {tkReset, tkCtrl, tkJedec, tkRead, tkBackPr, tkTiming} testKindT;

	typedef struct packed {
		testKindT    kind;
		logic [7:0]  clkDiv;
		logic [23:0] addr;     // flash address from the lcg
		logic [7:0]  nBytes;   // bytes read back
	} testRowT;

	logic        clk = 1'b0;
	logic        rstN;
	wbReqT       wbReq;
	wbRspT       wbRsp;
	logic        sck;
	logic        csN;
	logic        sdo;
	logic        sdi;
	int          cycleCnt = 0;
	int          sckEdges = 0;
	int          csFalls = 0;      // flash selections seen on the pin
	logic [31:0] lcgState;
	testRowT     rows [0:9];
	logic [7:0]  sentQ [$];    // bytes the flash should have logged
	int          logStart;
	longint      limitNs = 20000;   // margin on top of the transfer time
	logic        limitReady = 1'b0;

	always #4 clk = ~clk;
	always @(posedge clk) cycleCnt <= cycleCnt + 1;
	always @(posedge sck) sckEdges <= sckEdges + 1;
	always @(negedge csN) csFalls <= csFalls + 1;

	spiFlashTop u_dut (
		.clk   (clk),
		.rstN  (rstN),
		.wbReq (wbReq),
		.wbRsp (wbRsp),
		.sck   (sck),
		.csN   (csN),
		.sdo   (sdo),
		.sdi   (sdi)
	);

	flashModel u_flash (.sck(sck), .csN(csN), .sdo(sdo), .sdi(sdi));

	spiFlashChecker u_check (.clk(clk), .rstN(rstN), .wbReq(wbReq), .wbRsp(wbRsp));

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// clk cycles per byte, a zero divider runs as one
	function automatic int byteCycles(input logic [7:0] div);
		return 16 * ((div == 8'd0) ? 2 : div + 1);
	endfunction

	// one wishbone classic cycle, held until ack
	task automatic busAccess(
		input  logic               we,
		input  logic [wbAddrW-1:0] adr,
		input  logic [31:0]        wrDat,
		output logic [31:0]        rdDat,
		output int                 ackAt
	);
		@(negedge clk);
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we  = we;
		wbReq.adr = adr;
		wbReq.dat = wrDat;
		@(negedge clk);
		while (!wbRsp.ack) @(negedge clk);
		rdDat = wbRsp.dat;
		ackAt = cycleCnt;
		wbReq = '0;
	endtask

	task automatic setCtrl(input logic en, input logic [7:0] div);
		spiCtrlT     c;
		logic [31:0] rd;
		int          t;
		c        = '0;
		c.enable = en;
		c.clkDiv = div;
		busAccess(1'b1, regCtrl, c, rd, t);
		busAccess(1'b0, regCtrl, 32'h0, rd, t);
		u_check.checkValue("regCtrl", rd, c);
	endtask

	task automatic sendByte(input logic [7:0] b, output int ackAt);
		spiCmdT      cmd;
		logic [31:0] rd;
		cmd        = '0;
		cmd.txByte = b;
		sentQ.push_back(b);
		busAccess(1'b1, regData, cmd, rd, ackAt);   // stalls while a byte is in flight
	endtask

	// poll the status view until busy drops
	task automatic waitIdle(output int ackAt);
		spiStatT st;
		do begin
			busAccess(1'b0, regData, 32'h0, st, ackAt);
		end while (st.busy);
	endtask

	task automatic sendRelease();
		spiCmdT      cmd;
		logic [31:0] rd;
		int          t;
		int          k;
		cmd           = '0;
		cmd.releaseCs = 1'b1;
		busAccess(1'b1, regData, cmd, rd, t);
		k = 0;
		while (csN !== 1'b1 && k < 8) begin
			@(negedge clk);
			k++;
		end
		if (csN !== 1'b1) u_check.failNote("csN stayed low after the release command");
	endtask

	task automatic checkLog();
		int got;
		got = u_flash.rxCount - logStart;
		u_check.checkValue("flash byte count", got, sentQ.size());
		for (int i = 0; i < got && i < sentQ.size(); i++) begin
			u_check.checkValue($sformatf("flash byte %0d", i),
				u_flash.rxLog[logStart + i], sentQ[i]);
		end
	endtask

	task automatic runTest(input testRowT row);
		spiStatT     st;
		logic [31:0] r;
		int          t0;
		int          t1;
		int          edges;
		int          falls;
		int          n;
		n        = byteCycles(row.clkDiv);
		logStart = u_flash.rxCount;
		sentQ.delete();
		case (row.kind)
			tkReset: begin
				busAccess(1'b0, regCtrl, 32'h0, r, t0);
				u_check.checkValue("regCtrl", r, 32'(clkDivReset));   // enable 0
				busAccess(1'b0, regData, 32'h0, st, t0);
				u_check.checkValue("busy", st.busy, 0);
				u_check.checkValue("csN", csN, 1);
				u_check.checkValue("csN falls", csFalls, 0);
				u_check.checkValue("sck edges", sckEdges, 0);
			end
			tkCtrl: begin
				setCtrl(1'b1, row.clkDiv);
				setCtrl(1'b0, row.clkDiv);
				edges = sckEdges;
				falls = csFalls;
				sendByte(8'h5a, t0);     // acked and dropped
				sentQ.delete();
				repeat (40) @(negedge clk);
				busAccess(1'b0, regData, 32'h0, st, t0);
				u_check.checkValue("busy", st.busy, 0);
				u_check.checkValue("sck edges", sckEdges - edges, 0);
				u_check.checkValue("csN falls", csFalls - falls, 0);
				u_check.checkValue("csN", csN, 1);
			end
			tkJedec: begin
				setCtrl(1'b1, row.clkDiv);
				u_check.pushExpected(8'hef);
				u_check.pushExpected(8'h40);
				u_check.pushExpected(8'h15);
				sendByte(8'h9f, t0);
				repeat (3) begin
					sendByte(8'h00, t0);
					waitIdle(t1);
				end
			end
			tkRead: begin
				setCtrl(1'b1, row.clkDiv);
				for (int i = 0; i < row.nBytes; i++) begin
					u_check.pushExpected((row.addr[7:0] + 8'(i)) ^ 8'ha5);
				end
				sendByte(8'h03, t0);
				sendByte(row.addr[23:16], t0);
				sendByte(row.addr[15:8], t0);
				sendByte(row.addr[7:0], t0);
				repeat (row.nBytes) begin
					sendByte(8'h00, t0);
					waitIdle(t1);
					u_check.checkValue("csN", csN, 0);   // held across the burst
				end
			end
			tkBackPr: begin
				setCtrl(1'b1, row.clkDiv);
				r = nextRand();
				sendByte(r[23:16], t0);
				sendByte(r[15:8], t1);      // issued while the first is busy
				if (t1 - t0 < n) begin
					u_check.failNote($sformatf("second write acked after %0d cycles, %0d at least",
						t1 - t0, n));
				end
				waitIdle(t1);
			end
			tkTiming: begin
				setCtrl(1'b1, row.clkDiv);
				sendByte(8'h3c, t0);
				waitIdle(t1);
				// allow one poll period plus the bus latency
				if (t1 - t0 < n || t1 - t0 > n + 4) begin
					u_check.failNote($sformatf("busy lasted %0d cycles, %0d expected", t1 - t0, n));
				end
			end
		endcase
		if (row.kind != tkReset && row.kind != tkCtrl) sendRelease();
		checkLog();
	endtask

	// watchdog sized from the table
	initial begin
		wait (limitReady);
		#(limitNs);
		$display("watchdog: run hung after %0d ns", limitNs);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		rstN     = 1'b0;
		wbReq    = '0;
		lcgState = 32'h1733_328d;
		rows[0]  = '{tkReset, 8'd0, 24'h0, 8'd0};
		rows[1]  = '{tkCtrl, 8'd5, 24'h0, 8'd0};
		rows[2]  = '{tkJedec, 8'd1, 24'h0, 8'd3};
		rows[3]  = '{tkJedec, 8'd3, 24'h0, 8'd3};
		rows[4]  = '{tkRead, 8'd2, 24'h0, 8'd6};
		rows[5]  = '{tkRead, 8'd0, 24'h0, 8'd4};
		rows[6]  = '{tkBackPr, 8'd2, 24'h0, 8'd2};
		rows[7]  = '{tkTiming, 8'd1, 24'h0, 8'd1};
		rows[8]  = '{tkTiming, 8'd4, 24'h0, 8'd1};
		rows[9]  = '{tkTiming, 8'd0, 24'h0, 8'd1};
		foreach (rows[i]) begin
			rows[i].addr = 24'(nextRand() >> 8);
			limitNs += (rows[i].nBytes + 6) * byteCycles(rows[i].clkDiv) * 8;
		end
		limitReady = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		foreach (rows[i]) begin
			u_check.beginTest(i, rows[i].kind.name());
			runTest(rows[i]);
			u_check.endTest();
		end
		u_check.report();
		if (u_check.errCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
